/* all.f */
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/id_out_reg.sv
rtl/id_stage.sv
sim/id_stage_checker.sv
sim/id_stage_tb.sv

/* Makefile */
# make        build the testbench with Verilator and run it
# make lint   lint all sources with the testbench as top
# make clean  remove the build directory

VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim/id_stage_tb.sv */
// directed testbench for the decode stage, drives fetch, writeback and EX/MEM state, checks id_pkt
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb
	import id_pkg::*;
();

	logic            clock;
	logic            rst_n;
	if_id_t          if_pkt;
	logic            if_valid;
	logic            if_ready;
	wb_t             wb;
	stage_dest_t     ex_dest;
	stage_dest_t     mem_dest;
	id_ex_t          id_pkt;
	logic            id_valid;
	logic            id_ready;
	int              seed = 32'h7b5b;
	int              errors = 0;
	int              checks = 0;
	logic [xlen-1:0] model_regs [32]; // expected register contents
	id_ex_t          got_q [$];        // packets taken by the downstream stage

	id_stage uut (
		.clock    (clock),
		.rst_n    (rst_n),
		.if_pkt   (if_pkt),
		.if_valid (if_valid),
		.if_ready (if_ready),
		.wb       (wb),
		.ex_dest  (ex_dest),
		.mem_dest (mem_dest),
		.id_pkt   (id_pkt),
		.id_valid (id_valid),
		.id_ready (id_ready)
	);

	bind id_stage id_stage_checker u_chk (
		.clock    (clock),
		.rst_n    (rst_n),
		.if_ready (if_ready),
		.load_use (load_use),
		.id_pkt   (id_pkt),
		.id_valid (id_valid),
		.id_ready (id_ready)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;  // 100 ns period
	end

	// valid and ready at mid-cycle means consumed at the next edge
	always @(negedge clock) begin
		if (rst_n && id_valid && id_ready)
			got_q.push_back(id_pkt);
	end

	//////////////////////////////////////////////////////////////////////
	// rv32i encoders and expected packets
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [31:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [31:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	function automatic if_id_t at_pc(input logic [xlen-1:0] pc, input logic [xlen-1:0] inst);
		if_id_t p;
		p.pc   = pc;
		p.inst = inst;
		return p;
	endfunction

	function automatic stage_dest_t in_flight(input logic [4:0] idx, input logic is_load);
		stage_dest_t s;
		s.valid    = 1'b1;
		s.dest_idx = idx;
		s.rd_mem   = is_load;
		return s;
	endfunction

	// operands from the model, controls idle (add rs1 + rs2, no dest)
	function automatic id_ex_t base_pkt(input if_id_t p);
		id_ex_t e;
		e           = '0;
		e.pc        = p.pc;
		e.inst      = p.inst;
		e.rs1_value = model_regs[p.inst[19:15]];
		e.rs2_value = model_regs[p.inst[24:20]];
		e.opa_sel   = opa_rs1;
		e.opb_sel   = opb_rs2;
		e.alu_func  = alu_add;
		return e;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_pkt(input string name, input id_ex_t exp, input id_ex_t got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_fwd(input string name, input fwd_sel_e exp, input fwd_sel_e got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns %s expected %s got %s", $time, name, exp.name(), got.name());
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// drive tasks, each ends 10 ns after a rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic write_reg(input logic [4:0] idx, input logic [xlen-1:0] data);
		wb.en   = 1'b1;
		wb.idx  = idx;
		wb.data = data;
		if (idx != zero_reg)
			model_regs[idx] = data;  // x0 stays zero
		@(posedge clock);
		#10;
		wb.en = 1'b0;
	endtask

	// offer one instruction until the stage takes it
	task automatic send(input if_id_t p);
		int   n;
		logic taken;
		n        = 0;
		taken    = 1'b0;
		if_pkt   = p;
		if_valid = 1'b1;
		while (!taken && n < 20) begin
			@(negedge clock);
			taken = if_ready;
			@(posedge clock);
			#10;
			n++;
		end
		if_valid = 1'b0;
		if (!taken) begin
			errors++;
			$display("timeout: instruction %h at pc %h was never accepted", p.inst, p.pc);
		end
	endtask

	task automatic take_pkt(input string name, output id_ex_t pkt, output logic found);
		int n;
		n     = 0;
		found = 1'b0;
		pkt   = '0;
		while (got_q.size() == 0 && n < 20) begin
			@(posedge clock);
			#10;
			n++;
		end
		if (got_q.size() != 0) begin
			found = 1'b1;
			pkt   = got_q.pop_front();
		end else begin
			errors++;
			$display("timeout: no packet came out for %s", name);
		end
	endtask

	task automatic expect_next(input string name, input id_ex_t exp);
		id_ex_t got;
		logic   found;
		take_pkt(name, got, found);
		if (found)
			check_pkt(name, exp, got);
	endtask

	task automatic run_one(input string name, input if_id_t p, input id_ex_t exp);
		send(p);
		expect_next(name, exp);
	endtask

	task automatic fwd_case(input string name, input stage_dest_t ex, input stage_dest_t mem,
			input logic [31:0] inst, input fwd_sel_e exp_a, input fwd_sel_e exp_b);
		id_ex_t got;
		logic   found;
		ex_dest  = ex;
		mem_dest = mem;
		send(at_pc(32'h0000_0400, inst));
		take_pkt(name, got, found);
		if (found) begin
			check_fwd({name, " fwd_a"}, exp_a, got.fwd_a);
			check_fwd({name, " fwd_b"}, exp_b, got.fwd_b);
		end
	endtask

	task automatic illegal_case(input string name, input logic [31:0] inst);
		id_ex_t got;
		logic   found;
		send(at_pc(32'h0000_0700, inst));
		take_pkt(name, got, found);
		if (found) begin
			check_bit({name, " illegal"}, 1'b1, got.illegal);
			check_bit({name, " dest is x0"}, 1'b1, got.dest_idx == zero_reg);
			check_bit({name, " rd_mem"}, 1'b0, got.rd_mem);
			check_bit({name, " wr_mem"}, 1'b0, got.wr_mem);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_alu_decode();
		if_id_t          p;
		id_ex_t          e;
		logic [xlen-1:0] v;
		for (int i = 1; i < 8; i++)
			write_reg(5'(i), $random(seed));
		write_reg(zero_reg, $random(seed));  // dropped by the register file
		p = at_pc(32'h0000_0100, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3)); // add x3, x1, x2
		e = base_pkt(p);
		e.dest_idx = 5'd3;
		run_one("add", p, e);
		p = at_pc(32'h0000_0104, r_type(7'h20, 5'd6, 5'd5, 3'b000, 5'd4)); // sub x4, x5, x6
		e = base_pkt(p);
		e.dest_idx = 5'd4;
		e.alu_func = alu_sub;
		run_one("sub", p, e);
		p = at_pc(32'h0000_0108, r_type(7'h20, 5'd7, 5'd6, 3'b101, 5'd5)); // sra x5, x6, x7
		e = base_pkt(p);
		e.dest_idx = 5'd5;
		e.alu_func = alu_sra;
		run_one("sra", p, e);
		p = at_pc(32'h0000_010c, r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd8)); // x0 reads zero
		e = base_pkt(p);
		e.dest_idx = 5'd8;
		run_one("add x0", p, e);
		p = at_pc(32'h0000_0110, i_type(-5, 5'd7, 3'b100, 5'd9, op_imm));  // xori x9, x7, -5
		e = base_pkt(p);
		e.dest_idx = 5'd9;
		e.opb_sel  = opb_imm;
		e.alu_func = alu_xor;
		e.imm      = 32'hffff_fffb;
		run_one("xori", p, e);
		p = at_pc(32'h0000_0114, i_type(32'h405, 5'd1, 3'b101, 5'd10, op_imm)); // srai by 5
		e = base_pkt(p);
		e.dest_idx = 5'd10;
		e.opb_sel  = opb_imm;
		e.alu_func = alu_sra;
		e.imm      = 32'h0000_0405;
		run_one("srai", p, e);
		// write x11 in the same cycle that reads it
		v               = $random(seed);
		model_regs[11]  = v;
		wb.en           = 1'b1;
		wb.idx          = 5'd11;
		wb.data         = v;
		p = at_pc(32'h0000_0118, r_type(7'h00, 5'd0, 5'd11, 3'b000, 5'd12));
		e = base_pkt(p);
		e.dest_idx = 5'd12;
		send(p);
		wb.en = 1'b0;
		expect_next("bypass read", e);
	endtask

	task automatic test_immediates();
		if_id_t p;
		id_ex_t e;
		p = at_pc(32'h0000_0200, u_type(20'habcde, 5'd5, op_lui));
		e = base_pkt(p);
		e.dest_idx = 5'd5;
		e.opa_sel  = opa_zero;
		e.opb_sel  = opb_imm;
		e.imm      = 32'habcd_e000;
		run_one("lui", p, e);
		p = at_pc(32'h0000_0204, u_type(20'h80001, 5'd6, op_auipc));
		e = base_pkt(p);
		e.dest_idx = 5'd6;
		e.opa_sel  = opa_pc;
		e.opb_sel  = opb_imm;
		e.imm      = 32'h8000_1000;
		run_one("auipc", p, e);
		p = at_pc(32'h0000_0208, j_type(32'hfff5_a5a6, 5'd1));
		e = base_pkt(p);
		e.dest_idx      = 5'd1;
		e.opa_sel       = opa_pc;
		e.opb_sel       = opb_imm;
		e.imm           = 32'hfff5_a5a6;
		e.uncond_branch = 1'b1;
		run_one("jal", p, e);
		p = at_pc(32'h0000_020c, i_type(-4, 5'd2, 3'b000, 5'd1, op_jalr));
		e = base_pkt(p);
		e.dest_idx      = 5'd1;
		e.opb_sel       = opb_imm;
		e.imm           = 32'hffff_fffc;
		e.uncond_branch = 1'b1;
		run_one("jalr", p, e);
		p = at_pc(32'h0000_0210, b_type(32'hffff_f5a4, 5'd4, 5'd3, 3'b001)); // bne, no dest
		e = base_pkt(p);
		e.opa_sel     = opa_pc;
		e.opb_sel     = opb_imm;
		e.imm         = 32'hffff_f5a4;
		e.cond_branch = 1'b1;
		run_one("bne", p, e);
		p = at_pc(32'h0000_0214, i_type(32'h7ff, 5'd3, 3'b010, 5'd7, op_load)); // lw x7
		e = base_pkt(p);
		e.dest_idx = 5'd7;
		e.opb_sel  = opb_imm;
		e.imm      = 32'h0000_07ff;
		e.rd_mem   = 1'b1;
		run_one("lw", p, e);
		p = at_pc(32'h0000_0218, s_type(-8, 5'd4, 5'd5, 3'b010));           // sw x4, -8(x5)
		e = base_pkt(p);
		e.opb_sel = opb_imm;
		e.imm     = 32'hffff_fff8;
		e.wr_mem  = 1'b1;
		run_one("sw", p, e);
	endtask

	task automatic test_forwarding();
		logic [31:0] add_3_1_2;
		add_3_1_2 = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
		fwd_case("ex a mem b", in_flight(5'd1, 1'b0), in_flight(5'd2, 1'b0), add_3_1_2,
			fwd_ex, fwd_mem);
		fwd_case("ex over mem", in_flight(5'd2, 1'b0), in_flight(5'd2, 1'b0), add_3_1_2,
			fwd_none, fwd_ex);
		fwd_case("no match", in_flight(5'd5, 1'b0), in_flight(5'd6, 1'b0), add_3_1_2,
			fwd_none, fwd_none);
		fwd_case("store data", '0, in_flight(5'd1, 1'b0), s_type(0, 5'd1, 5'd1, 3'b010),
			fwd_mem, fwd_mem);
		fwd_case("x0 source", in_flight(5'd0, 1'b0), in_flight(5'd0, 1'b0),
			r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd3), fwd_none, fwd_none);
		// rs1 field of auipc is part of the immediate
		fwd_case("auipc", in_flight(5'd1, 1'b0), '0, u_type(20'h00008, 5'd3, op_auipc),
			fwd_none, fwd_none);
		ex_dest  = '0;
		mem_dest = '0;
	endtask

	task automatic test_load_use();
		if_id_t p;
		id_ex_t e;
		p = at_pc(32'h0000_0500, r_type(7'h00, 5'd1, 5'd4, 3'b000, 5'd5)); // add x5, x4, x1
		e = base_pkt(p);
		e.dest_idx = 5'd5;
		ex_dest    = in_flight(5'd4, 1'b1);  // lw x4 now in EX
		if_pkt     = p;
		if_valid   = 1'b1;
		repeat (4) begin
			@(negedge clock);
			check_bit("if_ready during load-use", 1'b0, if_ready);
			check_bit("id_valid during load-use", 1'b0, id_valid);
			@(posedge clock);
			#10;
		end
		ex_dest = '0;
		run_one("add after load-use", p, e);
	endtask

	task automatic test_back_pressure();
		if_id_t a, b, c;
		id_ex_t ea, eb, ec;
		int     n;
		a  = at_pc(32'h0000_0600, i_type(32'h11, 5'd1, 3'b000, 5'd13, op_imm)); // addi
		b  = at_pc(32'h0000_0604, r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd14));    // or
		c  = at_pc(32'h0000_0608, r_type(7'h00, 5'd5, 5'd4, 3'b111, 5'd15));    // and
		ea = base_pkt(a);
		ea.dest_idx = 5'd13;
		ea.opb_sel  = opb_imm;
		ea.imm      = 32'h0000_0011;
		eb = base_pkt(b);
		eb.dest_idx = 5'd14;
		eb.alu_func = alu_or;
		ec = base_pkt(c);
		ec.dest_idx = 5'd15;
		ec.alu_func = alu_and;
		n           = 0;
		id_ready    = 1'b0;
		fork
			begin
				send(a);
				send(b);
				send(c);
			end
			begin
				while (!id_valid && n < 20) begin
					@(negedge clock);
					n++;
				end
				if (!id_valid) begin
					errors++;
					$display("timeout: first packet never reached the output register");
				end
				repeat (5) begin
					@(negedge clock);
					check_bit("id_valid under back-pressure", 1'b1, id_valid);
					check_pkt("id_pkt under back-pressure", ea, id_pkt);
					check_bit("if_ready under back-pressure", 1'b0, if_ready);
				end
				@(posedge clock);
				#10;
				id_ready = 1'b1;
			end
		join
		expect_next("first after back-pressure", ea);
		expect_next("second after back-pressure", eb);
		expect_next("third after back-pressure", ec);
	endtask

	task automatic test_illegal_halt();
		id_ex_t got;
		logic   found;
		illegal_case("mul", r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd3));
		illegal_case("csrrw", i_type(32'h300, 5'd1, 3'b001, 5'd5, op_system));
		send(at_pc(32'h0000_0708, 32'h1050_0073)); // wfi
		take_pkt("wfi", got, found);
		if (found) begin
			check_bit("wfi halt", 1'b1, got.halt);
			check_bit("wfi illegal", 1'b0, got.illegal);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// sequence and report
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst_n    = 1'b0;
		if_pkt   = '0;
		if_valid = 1'b0;
		wb       = '0;
		ex_dest  = '0;
		mem_dest = '0;
		id_ready = 1'b1;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (10) @(posedge clock);
		#10;
		rst_n = 1'b1;
		@(negedge clock);
		check_bit("id_valid after reset", 1'b0, id_valid);
		check_bit("if_ready after reset", 1'b1, if_ready);
		@(posedge clock);
		#10;
		test_alu_decode();
		test_immediates();
		test_forwarding();
		test_load_use();
		test_back_pressure();
		test_illegal_halt();
		errors += uut.u_chk.fail_count;
		$display("checks: %0d  errors: %0d  assertion failures: %0d", checks, errors,
			uut.u_chk.fail_count);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// absolute limit on simulated time
	initial begin
		#1_000_000;
		$display("watchdog: simulation ran past its time limit");
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/id_stage_checker.sv */
// assertion checker bound into the decode stage top, watches reset, output hold and load-use stall
`timescale 1ns/1ps
`default_nettype none

module id_stage_checker
	import id_pkg::*;
(
	input logic   clock,
	input logic   rst_n,
	input logic   if_ready,
	input logic   load_use,   // internal net of the stage
	input id_ex_t id_pkt,
	input logic   id_valid,
	input logic   id_ready
);

	int fail_count = 0;  // summed into the testbench error count

	//////////////////////////////////////////////////////////////////////
	// handshake rules
	//////////////////////////////////////////////////////////////////////

	// nothing leaves the stage while reset is held
	reset_quiet: assert property (@(posedge clock) !rst_n |-> !id_valid)
		else begin
			fail_count++;
			$error("id_valid high while rst_n is low");
		end

	// a stalled packet stays put until taken
	out_hold: assert property (@(posedge clock) disable iff (!rst_n)
		(id_valid && !id_ready) |=> (id_valid && $stable(id_pkt)))
		else begin
			fail_count++;
			$error("id_pkt or id_valid changed under back-pressure");
		end

	load_use_closed: assert property (@(posedge clock) disable iff (!rst_n)
		load_use |-> !if_ready)
		else begin
			fail_count++;
			$error("if_ready high during load-use stall");
		end

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
// top of the single-issue decode stage, instances only, sits between fetch and execute
`timescale 1ns/1ps
`default_nettype none

module id_stage
	import id_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n,
	input  if_id_t      if_pkt,
	input  logic        if_valid,
	output logic        if_ready,
	input  wb_t         wb,
	input  stage_dest_t ex_dest,   // instruction in EX
	input  stage_dest_t mem_dest,  // instruction in MEM
	output id_ex_t      id_pkt,
	output logic        id_valid,
	input  logic        id_ready
);

	//////////////////////////////////////////////////////////////////////
	// internal nets
	//////////////////////////////////////////////////////////////////////

	ctrl_t                ctrl;
	logic [reg_idx_w-1:0] rs1_idx, rs2_idx;
	logic [xlen-1:0]      rs1_value, rs2_value;
	fwd_sel_e             fwd_a, fwd_b;
	logic                 load_use;

	assign rs1_idx = if_pkt.inst[19:15];
	assign rs2_idx = if_pkt.inst[24:20];

	//////////////////////////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////////////////////////

	inst_decoder u_dec (
		.inst  (if_pkt.inst),
		.valid (if_valid),
		.ctrl  (ctrl)
	);

	reg_file u_rf (
		.clock     (clock),
		.rst_n     (rst_n),
		.rs1_idx   (rs1_idx),
		.rs2_idx   (rs2_idx),
		.wb        (wb),
		.rs1_value (rs1_value),
		.rs2_value (rs2_value)
	);

	hazard_unit u_haz (
		.ctrl     (ctrl),
		.rs1_idx  (rs1_idx),
		.rs2_idx  (rs2_idx),
		.ex_dest  (ex_dest),
		.mem_dest (mem_dest),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b),
		.load_use (load_use)
	);

	id_out_reg u_out (
		.clock     (clock),
		.rst_n     (rst_n),
		.if_pkt    (if_pkt),
		.if_valid  (if_valid),
		.if_ready  (if_ready),
		.ctrl      (ctrl),
		.rs1_value (rs1_value),
		.rs2_value (rs2_value),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b),
		.load_use  (load_use),
		.id_pkt    (id_pkt),
		.id_valid  (id_valid),
		.id_ready  (id_ready)
	);

endmodule

`default_nettype wire

/* rtl/id_out_reg.sv */
// ID/EX pipeline register, forms the accept condition and holds the decoded packet under stall
`timescale 1ns/1ps
`default_nettype none

module id_out_reg
	import id_pkg::*;
(
	input  logic            clock,
	input  logic            rst_n,
	input  if_id_t          if_pkt,
	input  logic            if_valid,
	output logic            if_ready,
	input  ctrl_t           ctrl,
	input  logic [xlen-1:0] rs1_value,
	input  logic [xlen-1:0] rs2_value,
	input  fwd_sel_e        fwd_a,
	input  fwd_sel_e        fwd_b,
	input  logic            load_use,
	output id_ex_t          id_pkt,
	output logic            id_valid,
	input  logic            id_ready
);

	id_ex_t next_pkt;
	logic   accept;

	// open when empty or draining, closed on load-use
	assign if_ready = (!id_valid || id_ready) && !load_use;
	assign accept   = if_valid && if_ready;

	always_comb begin
		next_pkt               = '0;
		next_pkt.pc            = if_pkt.pc;
		next_pkt.inst          = if_pkt.inst;
		next_pkt.rs1_value     = rs1_value;
		next_pkt.rs2_value     = rs2_value;
		next_pkt.imm           = ctrl.imm;
		next_pkt.dest_idx      = ctrl.has_dest ? if_pkt.inst[11:7] : zero_reg; // rd
		next_pkt.opa_sel       = ctrl.opa_sel;
		next_pkt.opb_sel       = ctrl.opb_sel;
		next_pkt.alu_func      = ctrl.alu_func;
		next_pkt.fwd_a         = fwd_a;
		next_pkt.fwd_b         = fwd_b;
		next_pkt.rd_mem        = ctrl.rd_mem;
		next_pkt.wr_mem        = ctrl.wr_mem;
		next_pkt.cond_branch   = ctrl.cond_branch;
		next_pkt.uncond_branch = ctrl.uncond_branch;
		next_pkt.halt          = ctrl.halt;
		next_pkt.illegal       = ctrl.illegal;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
			id_pkt   <= '0;
		end else if (accept) begin
			id_valid <= 1'b1;
			id_pkt   <= next_pkt;
		end else if (id_ready) begin
			id_valid <= 1'b0;   // drained with nothing behind it
		end
	end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
// forwarding select per alu operand and load-use stall against the EX and MEM destinations
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
	import id_pkg::*;
(
	input  ctrl_t                ctrl,
	input  logic [reg_idx_w-1:0] rs1_idx,
	input  logic [reg_idx_w-1:0] rs2_idx,
	input  stage_dest_t          ex_dest,
	input  stage_dest_t          mem_dest,
	output fwd_sel_e             fwd_a,
	output fwd_sel_e             fwd_b,
	output logic                 load_use
);

	logic a_live, b_live;       // operand really read from a register
	logic rs1_ex_hit, rs2_ex_hit;

	// x0 never forwards
	function automatic logic hit(input logic [reg_idx_w-1:0] idx, input stage_dest_t st);
		hit = st.valid && (idx != zero_reg) && (st.dest_idx == idx);
	endfunction

	// EX is younger than MEM so it wins
	function automatic fwd_sel_e pick(input logic [reg_idx_w-1:0] idx, input logic live);
		if (!live)
			pick = fwd_none;
		else if (hit(idx, ex_dest))
			pick = fwd_ex;
		else if (hit(idx, mem_dest))
			pick = fwd_mem;
		else
			pick = fwd_none;
	endfunction

	assign a_live = ctrl.uses_rs1 && (ctrl.opa_sel == opa_rs1); // not pc / zero
	assign b_live = ctrl.uses_rs2;                             // also store data

	always_comb begin
		fwd_a = pick(rs1_idx, a_live);
		fwd_b = pick(rs2_idx, b_live);
	end

	//////////////////////////////////////////////////////////////////////
	// load-use
	//////////////////////////////////////////////////////////////////////

	// load data is not ready until MEM, so any used source waits a cycle
	assign rs1_ex_hit = ctrl.uses_rs1 && hit(rs1_idx, ex_dest);
	assign rs2_ex_hit = ctrl.uses_rs2 && hit(rs2_idx, ex_dest);
	assign load_use   = ex_dest.rd_mem && (rs1_ex_hit || rs2_ex_hit);

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
// 31-entry integer register file with two combinational reads and a write-through bypass
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import id_pkg::*;
(
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic [reg_idx_w-1:0] rs1_idx,
	input  logic [reg_idx_w-1:0] rs2_idx,
	input  wb_t                  wb,
	output logic [xlen-1:0]      rs1_value,
	output logic [xlen-1:0]      rs2_value
);

	logic [xlen-1:0] regs [1:31]; // x0 has no storage

	// one read port, x0 first, then the same-cycle writeback
	function automatic logic [xlen-1:0] read_port(input logic [reg_idx_w-1:0] idx);
		if (idx == zero_reg)
			read_port = '0;
		else if (wb.en && (wb.idx == idx))
			read_port = wb.data;   // bypass
		else
			read_port = regs[idx];
	endfunction

	always_comb begin
		rs1_value = read_port(rs1_idx);
		rs2_value = read_port(rs2_idx);
	end

	// writeback port, writes to x0 dropped
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.en && (wb.idx != zero_reg)) begin
			regs[wb.idx] <= wb.data;
		end
	end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
// combinational rv32i decoder, turns one instruction word into control fields and immediate
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
	import id_pkg::*;
(
	input  logic [xlen-1:0] inst,
	input  logic            valid,  // low gives a no-op
	output ctrl_t           ctrl
);

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	//////////////////////////////////////////////////////////////////////
	// immediate formats, all sign extended from inst[31]
	//////////////////////////////////////////////////////////////////////

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	//////////////////////////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;               // no-op, add rs1 + rs2 with nothing written
		ctrl.opa_sel  = opa_rs1;
		ctrl.opb_sel  = opb_rs2;
		ctrl.alu_func = alu_add;
		if (valid) begin
			case (opcode)
				op_lui: begin
					ctrl.has_dest = 1'b1;
					ctrl.opa_sel  = opa_zero;  // 0 + imm
					ctrl.opb_sel  = opb_imm;
					ctrl.imm      = imm_u;
				end
				op_auipc: begin
					ctrl.has_dest = 1'b1;
					ctrl.opa_sel  = opa_pc;
					ctrl.opb_sel  = opb_imm;
					ctrl.imm      = imm_u;
				end
				op_jal: begin
					ctrl.has_dest      = 1'b1;
					ctrl.opa_sel       = opa_pc;
					ctrl.opb_sel       = opb_imm;
					ctrl.imm           = imm_j;
					ctrl.uncond_branch = 1'b1;
				end
				op_jalr: begin
					ctrl.has_dest      = 1'b1;
					ctrl.uses_rs1      = 1'b1;
					ctrl.opb_sel       = opb_imm;
					ctrl.imm           = imm_i;
					ctrl.uncond_branch = 1'b1;
					ctrl.illegal       = (funct3 != 3'b000);
				end
				op_branch: begin
					ctrl.uses_rs1    = 1'b1;   // compare operands still come from rs1/rs2
					ctrl.uses_rs2    = 1'b1;
					ctrl.opa_sel     = opa_pc; // alu computes the target
					ctrl.opb_sel     = opb_imm;
					ctrl.imm         = imm_b;
					ctrl.cond_branch = 1'b1;
					ctrl.illegal     = (funct3 == 3'b010) || (funct3 == 3'b011);
				end
				op_load: begin
					ctrl.has_dest = 1'b1;
					ctrl.uses_rs1 = 1'b1;
					ctrl.opb_sel  = opb_imm;
					ctrl.imm      = imm_i;
					ctrl.rd_mem   = 1'b1;
					ctrl.illegal  = (funct3 == 3'b011) || (funct3[2:1] == 2'b11); // lb..lhu only
				end
				op_store: begin
					ctrl.uses_rs1 = 1'b1;
					ctrl.uses_rs2 = 1'b1;      // store data
					ctrl.opb_sel  = opb_imm;
					ctrl.imm      = imm_s;
					ctrl.wr_mem   = 1'b1;
					ctrl.illegal  = funct3[2] || (funct3 == 3'b011);
				end
				op_imm: begin
					ctrl.has_dest = 1'b1;
					ctrl.uses_rs1 = 1'b1;
					ctrl.opb_sel  = opb_imm;
					ctrl.imm      = imm_i;
					case (funct3)
						3'b000: ctrl.alu_func = alu_add;
						3'b010: ctrl.alu_func = alu_slt;
						3'b011: ctrl.alu_func = alu_sltu;
						3'b100: ctrl.alu_func = alu_xor;
						3'b110: ctrl.alu_func = alu_or;
						3'b111: ctrl.alu_func = alu_and;
						3'b001: begin
							ctrl.alu_func = alu_sll;
							ctrl.illegal  = (funct7 != 7'b0000000);
						end
						default: begin             // srli / srai, shamt in imm[4:0]
							ctrl.alu_func = funct7[5] ? alu_sra : alu_srl;
							ctrl.illegal  = ({funct7[6], funct7[4:0]} != 6'b0);
						end
					endcase
				end
				op_reg: begin
					ctrl.has_dest = 1'b1;
					ctrl.uses_rs1 = 1'b1;
					ctrl.uses_rs2 = 1'b1;
					case ({funct7, funct3})
						10'b0000000_000: ctrl.alu_func = alu_add;
						10'b0100000_000: ctrl.alu_func = alu_sub;
						10'b0000000_001: ctrl.alu_func = alu_sll;
						10'b0000000_010: ctrl.alu_func = alu_slt;
						10'b0000000_011: ctrl.alu_func = alu_sltu;
						10'b0000000_100: ctrl.alu_func = alu_xor;
						10'b0000000_101: ctrl.alu_func = alu_srl;
						10'b0100000_101: ctrl.alu_func = alu_sra;
						10'b0000000_110: ctrl.alu_func = alu_or;
						10'b0000000_111: ctrl.alu_func = alu_and;
						default:         ctrl.illegal  = 1'b1; // mul/div land here
					endcase
				end
				op_system: begin
					if (inst == wfi_inst) ctrl.halt = 1'b1;
					else ctrl.illegal = 1'b1;  // csr, ecall, ebreak unsupported
				end
				default: ctrl.illegal = 1'b1;
			endcase

			// an illegal instruction must not write anything downstream
			if (ctrl.illegal) begin
				ctrl.has_dest      = 1'b0;
				ctrl.rd_mem        = 1'b0;
				ctrl.wr_mem        = 1'b0;
				ctrl.cond_branch   = 1'b0;
				ctrl.uncond_branch = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/id_pkg.sv */
// shared widths, encodings and packet types of the decode stage, compiled ahead of all rtl
`default_nettype none

package id_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and constants
	//////////////////////////////////////////////////////////////////////

	localparam int xlen      = 32;                            // data width
	localparam int reg_idx_w = 5;                             // register index width
	localparam logic [reg_idx_w-1:0] zero_reg = '0;           // x0 reads as zero
	localparam logic [xlen-1:0]      wfi_inst = 32'h1050_0073; // full wfi encoding

	//////////////////////////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////////////////////////

	// rv32i major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_system = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add  = 4'h0,
		alu_sub  = 4'h1,
		alu_slt  = 4'h2,
		alu_sltu = 4'h3,
		alu_and  = 4'h4,
		alu_or   = 4'h5,
		alu_xor  = 4'h6,
		alu_sll  = 4'h7,
		alu_srl  = 4'h8,
		alu_sra  = 4'h9
	} alu_func_e;

	typedef enum logic [1:0] {
		opa_rs1  = 2'd0,
		opa_pc   = 2'd1,
		opa_zero = 2'd2
	} opa_sel_e;

	typedef enum logic {
		opb_rs2 = 1'b0,
		opb_imm = 1'b1  // imm already picked by the decoder
	} opb_sel_e;

	// where EX takes an operand from
	typedef enum logic [1:0] {
		fwd_none = 2'd0, // register file value
		fwd_ex   = 2'd1, // result of the instruction now in EX
		fwd_mem  = 2'd2  // result of the instruction now in MEM
	} fwd_sel_e;

	//////////////////////////////////////////////////////////////////////
	// packets
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] inst;
	} if_id_t;

	typedef struct packed {
		logic                 en;
		logic [reg_idx_w-1:0] idx;
		logic [xlen-1:0]      data;
	} wb_t;

	// one downstream stage as seen from decode
	typedef struct packed {
		logic                 valid;
		logic [reg_idx_w-1:0] dest_idx;
		logic                 rd_mem;   // a load sits in this stage
	} stage_dest_t;

	typedef struct packed {
		opa_sel_e        opa_sel;
		opb_sel_e        opb_sel;
		alu_func_e       alu_func;
		logic            has_dest;
		logic            uses_rs1;
		logic            uses_rs2;
		logic            rd_mem;
		logic            wr_mem;
		logic            cond_branch;
		logic            uncond_branch;
		logic            halt;
		logic            illegal;
		logic [xlen-1:0] imm;
	} ctrl_t;

	typedef struct packed {
		logic [xlen-1:0]      pc;
		logic [xlen-1:0]      inst;
		logic [xlen-1:0]      rs1_value;
		logic [xlen-1:0]      rs2_value;
		logic [xlen-1:0]      imm;
		logic [reg_idx_w-1:0] dest_idx;
		opa_sel_e             opa_sel;
		opb_sel_e             opb_sel;
		alu_func_e            alu_func;
		fwd_sel_e             fwd_a;
		fwd_sel_e             fwd_b;
		logic                 rd_mem;
		logic                 wr_mem;
		logic                 cond_branch;
		logic                 uncond_branch;
		logic                 halt;
		logic                 illegal;
	} id_ex_t;

endpackage

`default_nettype wire
